// ==== logic/rs_config_pkg.sv ====
package rs_config_pkg;

    // Station and port sizes
    localparam int RS_DEPTH       = 8;
    localparam int DISPATCH_WIDTH = 2;
    localparam int CDB_WIDTH      = 2;

    // Functional unit pools
    localparam int NUM_ALU  = 2;
    localparam int NUM_MULT = 1;
    localparam int NUM_MEM  = 1;

    // Operand and payload widths
    localparam int TAG_WIDTH     = 6;
    localparam int PAYLOAD_WIDTH = 16;

    // Open-entry count never exceeds the dispatch width
    localparam int OPEN_WIDTH  = $clog2(DISPATCH_WIDTH + 1);
    localparam int COUNT_WIDTH = $clog2(RS_DEPTH + 1);

    typedef logic [OPEN_WIDTH-1:0]  open_count_t;
    typedef logic [COUNT_WIDTH-1:0] occ_count_t;

endpackage

// ==== logic/rs_packet_pkg.sv ====
package rs_packet_pkg;

    typedef enum logic [1:0] {
        FU_ALU,
        FU_MULT,
        FU_MEM
    } fu_class_t;

    typedef struct packed {
        logic [rs_config_pkg::TAG_WIDTH-1:0] tag;
        logic                                ready;
    } src_tag_t;

    // Decoded instruction arriving from rename
    typedef struct packed {
        logic                                    valid;
        fu_class_t                               fu_class;
        logic [rs_config_pkg::TAG_WIDTH-1:0]     dest_tag;
        src_tag_t                                src1;
        src_tag_t                                src2;
        logic [rs_config_pkg::PAYLOAD_WIDTH-1:0] payload;
    } dispatch_packet_t;

    typedef struct packed {
        logic                                valid;
        logic [rs_config_pkg::TAG_WIDTH-1:0] tag;
    } cdb_packet_t;

    // One slot; valid marks it occupied
    typedef struct packed {
        logic                                    valid;
        fu_class_t                               fu_class;
        logic [rs_config_pkg::TAG_WIDTH-1:0]     dest_tag;
        src_tag_t                                src1;
        src_tag_t                                src2;
        logic [rs_config_pkg::PAYLOAD_WIDTH-1:0] payload;
    } rs_entry_t;

    typedef struct packed {
        logic                                    valid;
        fu_class_t                               fu_class;
        logic [rs_config_pkg::TAG_WIDTH-1:0]     dest_tag;
        logic [rs_config_pkg::TAG_WIDTH-1:0]     src1_tag;
        logic [rs_config_pkg::TAG_WIDTH-1:0]     src2_tag;
        logic [rs_config_pkg::PAYLOAD_WIDTH-1:0] payload;
    } issue_packet_t;

endpackage

// ==== logic/psel_gen.sv ====
module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]           req,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus
);

    // Each stage peels the lowest remaining request off the vector
    always_comb begin : peel
        logic [WIDTH-1:0] remaining;
        logic [WIDTH-1:0] lowest;

        remaining = req;
        for (int r = 0; r < REQS; r++) begin
            // Two's complement trick isolates the lowest set bit
            lowest = remaining & (~remaining + WIDTH'(1));
            gnt_bus[r] = lowest;
            remaining = remaining & ~lowest;
        end
    end

endmodule

// ==== logic/rs_issue_select.sv ====
module rs_issue_select #(
    parameter rs_packet_pkg::fu_class_t FU_CLASS = rs_packet_pkg::FU_ALU,
    parameter int                       NUM_FU   = 1
) (
    input  rs_packet_pkg::rs_entry_t [rs_config_pkg::RS_DEPTH-1:0] entries,
    input  logic [NUM_FU-1:0]                                       fu_busy,
    output rs_packet_pkg::issue_packet_t [NUM_FU-1:0]               issued,
    output logic [rs_config_pkg::RS_DEPTH-1:0]                      issued_slots
);

    logic [rs_config_pkg::RS_DEPTH-1:0]             req;
    logic [NUM_FU-1:0][rs_config_pkg::RS_DEPTH-1:0] slot_gnt;
    logic [NUM_FU-1:0][rs_config_pkg::RS_DEPTH-1:0] unit_gnt;

    // Occupied slots of this class with both operands ready
    always_comb begin
        for (int s = 0; s < rs_config_pkg::RS_DEPTH; s++) begin
            req[s] = entries[s].valid && (entries[s].fu_class == FU_CLASS)
                && entries[s].src1.ready && entries[s].src2.ready;
        end
    end

    psel_gen #(
        .WIDTH (rs_config_pkg::RS_DEPTH),
        .REQS  (NUM_FU)
    ) slot_pick (
        .req     (req),
        .gnt_bus (slot_gnt)
    );

    // k-th picked slot goes to the k-th idle unit
    always_comb begin : route
        int k;

        k = 0;
        unit_gnt = '0;
        for (int u = 0; u < NUM_FU; u++) begin
            if (!fu_busy[u]) begin
                unit_gnt[u] = slot_gnt[k];
                k++;
            end
        end
    end

    always_comb begin
        issued = '0;
        issued_slots = '0;
        for (int u = 0; u < NUM_FU; u++) begin
            issued[u].valid = |unit_gnt[u];
            issued_slots = issued_slots | unit_gnt[u];
            for (int s = 0; s < rs_config_pkg::RS_DEPTH; s++) begin
                if (unit_gnt[u][s]) begin
                    issued[u].fu_class = entries[s].fu_class;
                    issued[u].dest_tag = entries[s].dest_tag;
                    issued[u].src1_tag = entries[s].src1.tag;
                    issued[u].src2_tag = entries[s].src2.tag;
                    issued[u].payload  = entries[s].payload;
                end
            end
        end
    end

endmodule

// ==== logic/rs_entry_array.sv ====
module rs_entry_array (
    input  logic                                                            clock,
    input  logic                                                            reset,
    input  rs_packet_pkg::dispatch_packet_t [rs_config_pkg::DISPATCH_WIDTH-1:0] dispatch,
    input  logic [rs_config_pkg::DISPATCH_WIDTH-1:0][rs_config_pkg::RS_DEPTH-1:0] dispatch_gnt,
    input  rs_packet_pkg::cdb_packet_t [rs_config_pkg::CDB_WIDTH-1:0]       cdb,
    input  logic [rs_config_pkg::RS_DEPTH-1:0]                              release_slots,
    output rs_packet_pkg::rs_entry_t [rs_config_pkg::RS_DEPTH-1:0]          entries,
    output logic [rs_config_pkg::RS_DEPTH-1:0]                              free_slots,
    output rs_config_pkg::open_count_t                                      open_entries
);

    logic [rs_config_pkg::RS_DEPTH-1:0]                     occupied;
    logic [rs_config_pkg::RS_DEPTH-1:0]                     next_occupied;
    rs_packet_pkg::rs_entry_t [rs_config_pkg::RS_DEPTH-1:0] slot_q;
    rs_packet_pkg::rs_entry_t [rs_config_pkg::RS_DEPTH-1:0] next_slot;
    rs_config_pkg::occ_count_t                              count_q;
    rs_config_pkg::occ_count_t                              next_count;
    rs_config_pkg::occ_count_t                              free_count;

    // Order within a cycle is release, then wakeup, then dispatch writes
    always_comb begin : update
        rs_packet_pkg::dispatch_packet_t incoming;
        int n_write;
        int n_release;

        next_occupied = occupied & ~release_slots;
        next_slot = slot_q;
        n_write = 0;
        n_release = $countones(release_slots & occupied);

        // CDB wakeup of waiting sources
        for (int j = 0; j < rs_config_pkg::RS_DEPTH; j++) begin
            for (int c = 0; c < rs_config_pkg::CDB_WIDTH; c++) begin
                if (cdb[c].valid && occupied[j]) begin
                    if (slot_q[j].src1.tag == cdb[c].tag) begin
                        next_slot[j].src1.ready = 1'b1;
                    end
                    if (slot_q[j].src2.tag == cdb[c].tag) begin
                        next_slot[j].src2.ready = 1'b1;
                    end
                end
            end
        end

        for (int i = 0; i < rs_config_pkg::DISPATCH_WIDTH; i++) begin
            incoming = dispatch[i];
            // Same-cycle broadcast counts for the incoming packet too
            for (int c = 0; c < rs_config_pkg::CDB_WIDTH; c++) begin
                if (cdb[c].valid && (incoming.src1.tag == cdb[c].tag)) begin
                    incoming.src1.ready = 1'b1;
                end
                if (cdb[c].valid && (incoming.src2.tag == cdb[c].tag)) begin
                    incoming.src2.ready = 1'b1;
                end
            end
            if (incoming.valid && |dispatch_gnt[i]) begin
                n_write++;
                for (int j = 0; j < rs_config_pkg::RS_DEPTH; j++) begin
                    if (dispatch_gnt[i][j]) begin
                        next_occupied[j]      = 1'b1;
                        next_slot[j].valid    = 1'b1;
                        next_slot[j].fu_class = incoming.fu_class;
                        next_slot[j].dest_tag = incoming.dest_tag;
                        next_slot[j].src1     = incoming.src1;
                        next_slot[j].src2     = incoming.src2;
                        next_slot[j].payload  = incoming.payload;
                    end
                end
            end
        end

        next_count = rs_config_pkg::occ_count_t'(int'(count_q) + n_write - n_release);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            occupied <= '0;
            count_q  <= '0;
        end else begin
            occupied <= next_occupied;
            count_q  <= next_count;
        end
    end

    always_ff @(posedge clock) begin
        slot_q <= next_slot;
    end

    // Occupancy bit overrides whatever a stale slot holds
    always_comb begin
        for (int j = 0; j < rs_config_pkg::RS_DEPTH; j++) begin
            entries[j] = slot_q[j];
            entries[j].valid = occupied[j];
        end
    end

    assign free_slots = ~occupied;
    assign free_count = rs_config_pkg::occ_count_t'(rs_config_pkg::RS_DEPTH) - count_q;
    assign open_entries =
        (free_count > rs_config_pkg::occ_count_t'(rs_config_pkg::DISPATCH_WIDTH))
            ? rs_config_pkg::open_count_t'(rs_config_pkg::DISPATCH_WIDTH)
            : rs_config_pkg::open_count_t'(free_count);

endmodule

// ==== logic/rs_top.sv ====
module rs_top (
    input  logic                                                                clock,
    input  logic                                                                reset,
    input  rs_packet_pkg::dispatch_packet_t [rs_config_pkg::DISPATCH_WIDTH-1:0] dispatch,
    input  rs_packet_pkg::cdb_packet_t [rs_config_pkg::CDB_WIDTH-1:0]           cdb,
    input  logic [rs_config_pkg::NUM_ALU-1:0]                                   alu_busy,
    input  logic [rs_config_pkg::NUM_MULT-1:0]                                  mult_busy,
    input  logic [rs_config_pkg::NUM_MEM-1:0]                                   mem_busy,
    output rs_packet_pkg::issue_packet_t [rs_config_pkg::NUM_ALU-1:0]           alu_issue,
    output rs_packet_pkg::issue_packet_t [rs_config_pkg::NUM_MULT-1:0]          mult_issue,
    output rs_packet_pkg::issue_packet_t [rs_config_pkg::NUM_MEM-1:0]           mem_issue,
    output rs_config_pkg::open_count_t                                          open_entries
);

    rs_packet_pkg::rs_entry_t [rs_config_pkg::RS_DEPTH-1:0]                      entries;
    logic [rs_config_pkg::RS_DEPTH-1:0]                                          free_slots;
    logic [rs_config_pkg::DISPATCH_WIDTH-1:0][rs_config_pkg::RS_DEPTH-1:0]       dispatch_gnt;
    logic [rs_config_pkg::RS_DEPTH-1:0]                                          alu_slots;
    logic [rs_config_pkg::RS_DEPTH-1:0]                                          mult_slots;
    logic [rs_config_pkg::RS_DEPTH-1:0]                                          mem_slots;
    logic [rs_config_pkg::RS_DEPTH-1:0]                                          release_slots;

    assign release_slots = alu_slots | mult_slots | mem_slots;

    rs_entry_array entry_array (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .dispatch_gnt  (dispatch_gnt),
        .cdb           (cdb),
        .release_slots (release_slots),
        .entries       (entries),
        .free_slots    (free_slots),
        .open_entries  (open_entries)
    );

    // Lane 0 takes the lowest free slot, lane 1 the next
    psel_gen #(
        .WIDTH (rs_config_pkg::RS_DEPTH),
        .REQS  (rs_config_pkg::DISPATCH_WIDTH)
    ) dispatch_select (
        .req     (free_slots),
        .gnt_bus (dispatch_gnt)
    );

    rs_issue_select #(
        .FU_CLASS (rs_packet_pkg::FU_ALU),
        .NUM_FU   (rs_config_pkg::NUM_ALU)
    ) alu_select (
        .entries      (entries),
        .fu_busy      (alu_busy),
        .issued       (alu_issue),
        .issued_slots (alu_slots)
    );

    rs_issue_select #(
        .FU_CLASS (rs_packet_pkg::FU_MULT),
        .NUM_FU   (rs_config_pkg::NUM_MULT)
    ) mult_select (
        .entries      (entries),
        .fu_busy      (mult_busy),
        .issued       (mult_issue),
        .issued_slots (mult_slots)
    );

    rs_issue_select #(
        .FU_CLASS (rs_packet_pkg::FU_MEM),
        .NUM_FU   (rs_config_pkg::NUM_MEM)
    ) mem_select (
        .entries      (entries),
        .fu_busy      (mem_busy),
        .issued       (mem_issue),
        .issued_slots (mem_slots)
    );

endmodule

// ==== bench/rs_tb_util.svh ====
// LFSR state shared by every random draw
logic [31:0] lfsr_state = 32'hba9184a5;

// Tags each outstanding payload still awaits and the fields it must issue with
logic [63:0] wait_set [int];
int          pay_class [int];
int          pay_dest [int];
int          pay_src1 [int];
int          pay_src2 [int];
int          next_payload = 0;
int          last_payload;

function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ 32'ha3000000;
    end
    return out;
endfunction

function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
        r = (r << 1) | int'(lfsr_bit());
    end
    return r;
endfunction

task automatic queue_dispatch(input int lane, input rs_packet_pkg::fu_class_t cls,
                              input int dest, input int tag1, input bit rdy1,
                              input int tag2, input bit rdy2);
    next_payload++;
    dispatch_next[lane].valid      = 1'b1;
    dispatch_next[lane].fu_class   = cls;
    dispatch_next[lane].dest_tag   = dest[rs_config_pkg::TAG_WIDTH-1:0];
    dispatch_next[lane].src1.tag   = tag1[rs_config_pkg::TAG_WIDTH-1:0];
    dispatch_next[lane].src1.ready = rdy1;
    dispatch_next[lane].src2.tag   = tag2[rs_config_pkg::TAG_WIDTH-1:0];
    dispatch_next[lane].src2.ready = rdy2;
    dispatch_next[lane].payload    = next_payload[rs_config_pkg::PAYLOAD_WIDTH-1:0];
    last_payload = next_payload;
endtask

task automatic queue_broadcast(input int lane, input int tag);
    cdb_next[lane].valid = 1'b1;
    cdb_next[lane].tag   = tag[rs_config_pkg::TAG_WIDTH-1:0];
endtask

task automatic track_dispatch(input rs_packet_pkg::dispatch_packet_t p);
    logic [63:0] w;
    int pay;
    w = '0;
    if (!p.src1.ready) w[p.src1.tag] = 1'b1;
    if (!p.src2.ready) w[p.src2.tag] = 1'b1;
    // A tag on the bus in the same cycle counts as already delivered
    for (int c = 0; c < rs_config_pkg::CDB_WIDTH; c++) begin
        if (cdb[c].valid) w[cdb[c].tag] = 1'b0;
    end
    pay = int'(p.payload);
    wait_set[pay]  = w;
    pay_class[pay] = int'(p.fu_class);
    pay_dest[pay]  = int'(p.dest_tag);
    pay_src1[pay]  = int'(p.src1.tag);
    pay_src2[pay]  = int'(p.src2.tag);
endtask

// ==== bench/rs_tb.sv ====
module rs_tb;

    localparam int CYCLE_LIMIT   = 2000;
    localparam int RANDOM_CYCLES = 400;
    localparam int DW            = rs_config_pkg::DISPATCH_WIDTH;

    logic clock;
    logic reset;
    rs_packet_pkg::dispatch_packet_t [DW-1:0]                      dispatch;
    rs_packet_pkg::cdb_packet_t [rs_config_pkg::CDB_WIDTH-1:0]     cdb;
    logic [rs_config_pkg::NUM_ALU-1:0]                             alu_busy;
    logic [rs_config_pkg::NUM_MULT-1:0]                            mult_busy;
    logic [rs_config_pkg::NUM_MEM-1:0]                             mem_busy;
    rs_packet_pkg::issue_packet_t [rs_config_pkg::NUM_ALU-1:0]     alu_issue;
    rs_packet_pkg::issue_packet_t [rs_config_pkg::NUM_MULT-1:0]    mult_issue;
    rs_packet_pkg::issue_packet_t [rs_config_pkg::NUM_MEM-1:0]     mem_issue;
    rs_config_pkg::open_count_t                                    open_entries;
    logic [rs_config_pkg::NUM_ALU-1:0]                             alu_valid;
    logic [rs_config_pkg::NUM_MULT-1:0]                            mult_valid;
    logic [rs_config_pkg::NUM_MEM-1:0]                             mem_valid;

    // Stimulus applied at the next rising edge
    rs_packet_pkg::dispatch_packet_t [DW-1:0]                      dispatch_next;
    rs_packet_pkg::cdb_packet_t [rs_config_pkg::CDB_WIDTH-1:0]     cdb_next;
    logic [rs_config_pkg::NUM_ALU-1:0]                             alu_busy_next;
    logic [rs_config_pkg::NUM_MULT-1:0]                            mult_busy_next;
    logic [rs_config_pkg::NUM_MEM-1:0]                             mem_busy_next;

    int    cycle_count = 0;
    int    errors = 0;
    int    test_errors = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    string test_name = "reset";

    rs_top dut0 (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .cdb          (cdb),
        .alu_busy     (alu_busy),
        .mult_busy    (mult_busy),
        .mem_busy     (mem_busy),
        .alu_issue    (alu_issue),
        .mult_issue   (mult_issue),
        .mem_issue    (mem_issue),
        .open_entries (open_entries)
    );

    task automatic fault(input string what);
        errors++;
        test_errors++;
        $display("%s: %s", test_name, what);
    endtask

    task automatic value_error(input string what, input int expected, input int actual);
        errors++;
        test_errors++;
        $display("** Error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
    endtask

    `include "rs_tb_util.svh"

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    always_comb begin
        for (int u = 0; u < rs_config_pkg::NUM_ALU; u++) alu_valid[u] = alu_issue[u].valid;
        for (int u = 0; u < rs_config_pkg::NUM_MULT; u++) mult_valid[u] = mult_issue[u].valid;
        for (int u = 0; u < rs_config_pkg::NUM_MEM; u++) mem_valid[u] = mem_issue[u].valid;
    end

    // A busy unit never receives an instruction
    alu_busy_check: assert property (@(posedge clock) disable iff (reset)
        (alu_valid & alu_busy) == '0) else fault("an alu issue appeared on a busy unit");
    mult_busy_check: assert property (@(posedge clock) disable iff (reset)
        (mult_valid & mult_busy) == '0) else fault("a mult issue appeared on a busy unit");
    mem_busy_check: assert property (@(posedge clock) disable iff (reset)
        (mem_valid & mem_busy) == '0) else fault("a mem issue appeared on a busy unit");

    task automatic check_port(input int pool, input rs_packet_pkg::issue_packet_t p);
        int pay;
        if (p.valid) begin
            pay = int'(p.payload);
            assert (wait_set.exists(pay))
                else fault($sformatf("payload %0d issued but not outstanding", pay));
            if (wait_set.exists(pay)) begin
                assert (pay_class[pay] == pool)
                    else value_error("issue pool", pay_class[pay], pool);
                assert (int'(p.fu_class) == pay_class[pay])
                    else value_error("issue class", pay_class[pay], int'(p.fu_class));
                assert (wait_set[pay] == '0)
                    else fault($sformatf("payload %0d issued before its tags arrived", pay));
                assert (pay_dest[pay] == int'(p.dest_tag))
                    else value_error("destination tag", pay_dest[pay], int'(p.dest_tag));
                assert (pay_src1[pay] == int'(p.src1_tag))
                    else value_error("source 1 tag", pay_src1[pay], int'(p.src1_tag));
                assert (pay_src2[pay] == int'(p.src2_tag))
                    else value_error("source 2 tag", pay_src2[pay], int'(p.src2_tag));
                wait_set.delete(pay);
                pay_class.delete(pay);
                pay_dest.delete(pay);
                pay_src1.delete(pay);
                pay_src2.delete(pay);
            end
        end
    endtask

    // Compare one cycle of outputs against the reference, then update it
    task automatic check_cycle();
        int room;
        room = rs_config_pkg::RS_DEPTH - wait_set.num();
        if (room > DW) room = DW;
        assert (int'(open_entries) == room)
            else value_error("open_entries", room, int'(open_entries));
        for (int u = 0; u < rs_config_pkg::NUM_ALU; u++) check_port(0, alu_issue[u]);
        for (int u = 0; u < rs_config_pkg::NUM_MULT; u++) check_port(1, mult_issue[u]);
        for (int u = 0; u < rs_config_pkg::NUM_MEM; u++) check_port(2, mem_issue[u]);
        for (int c = 0; c < rs_config_pkg::CDB_WIDTH; c++) begin
            if (cdb[c].valid) begin
                foreach (wait_set[k]) wait_set[k][cdb[c].tag] = 1'b0;
            end
        end
        for (int i = 0; i < DW; i++) begin
            if (dispatch[i].valid) track_dispatch(dispatch[i]);
        end
    endtask

    task automatic run_cycle();
        @(posedge clock);
        dispatch  <= dispatch_next;
        cdb       <= cdb_next;
        alu_busy  <= alu_busy_next;
        mult_busy <= mult_busy_next;
        mem_busy  <= mem_busy_next;
        @(negedge clock);
        check_cycle();
        dispatch_next = '0;
        cdb_next = '0;
    endtask

    task automatic drain();
        logic [63:0] waiting;
        int lane;
        alu_busy_next = '0;
        mult_busy_next = '0;
        mem_busy_next = '0;
        for (int n = 0; n < 100 && wait_set.num() > 0; n++) begin
            waiting = '0;
            foreach (wait_set[k]) waiting = waiting | wait_set[k];
            lane = 0;
            for (int t = 0; t < 64 && lane < rs_config_pkg::CDB_WIDTH; t++) begin
                if (waiting[t]) begin
                    queue_broadcast(lane, t);
                    lane++;
                end
            end
            run_cycle();
        end
        assert (wait_set.num() == 0) else fault("outstanding entries never issued");
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    initial begin
        int pay;
        int n;
        reset = 1'b1;
        dispatch = '0;
        cdb = '0;
        alu_busy = '0;
        mult_busy = '0;
        mem_busy = '0;
        dispatch_next = '0;
        cdb_next = '0;
        alu_busy_next = '0;
        mult_busy_next = '0;
        mem_busy_next = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        start_test("reset");
        assert ((alu_valid | mult_valid | mem_valid) == '0)
            else fault("an issue valid was high after reset");
        assert (int'(open_entries) == DW) else value_error("open_entries", DW, int'(open_entries));
        finish_test();

        start_test("direct issue");
        queue_dispatch(0, rs_packet_pkg::FU_ALU, 1, 2, 1'b1, 3, 1'b1);
        pay = last_payload;
        queue_dispatch(1, rs_packet_pkg::FU_MULT, 4, 5, 1'b1, 6, 1'b1);
        run_cycle();
        run_cycle();
        assert (alu_issue[0].valid && int'(alu_issue[0].payload) == pay)
            else value_error("alu unit 0 payload", pay, int'(alu_issue[0].payload));
        assert (mult_issue[0].valid && int'(mult_issue[0].payload) == pay + 1)
            else value_error("mult unit 0 payload", pay + 1, int'(mult_issue[0].payload));
        finish_test();

        start_test("wakeup");
        queue_dispatch(0, rs_packet_pkg::FU_MEM, 7, 40, 1'b0, 41, 1'b1);
        pay = last_payload;
        repeat (4) begin
            run_cycle();
            assert (!mem_issue[0].valid) else fault("mem entry issued before its tag was broadcast");
        end
        queue_broadcast(0, 40);
        run_cycle();
        assert (!mem_issue[0].valid) else fault("mem entry issued in the broadcast cycle");
        run_cycle();
        assert (mem_issue[0].valid && int'(mem_issue[0].payload) == pay)
            else value_error("woken mem payload", pay, int'(mem_issue[0].payload));
        queue_dispatch(0, rs_packet_pkg::FU_MULT, 8, 42, 1'b1, 43, 1'b0);
        pay = last_payload;
        queue_broadcast(1, 43);
        run_cycle();
        run_cycle();
        assert (mult_issue[0].valid && int'(mult_issue[0].payload) == pay)
            else value_error("bypassed mult payload", pay, int'(mult_issue[0].payload));
        finish_test();

        start_test("unit selection");
        alu_busy_next = 2'b01;
        queue_dispatch(0, rs_packet_pkg::FU_ALU, 9, 1, 1'b1, 2, 1'b1);
        queue_dispatch(1, rs_packet_pkg::FU_ALU, 10, 1, 1'b1, 2, 1'b1);
        run_cycle();
        queue_dispatch(0, rs_packet_pkg::FU_ALU, 11, 1, 1'b1, 2, 1'b1);
        repeat (3) begin
            run_cycle();
            assert (alu_valid == 2'b10) else value_error("alu valid vector", 2, int'(alu_valid));
        end
        alu_busy_next = '0;
        queue_dispatch(0, rs_packet_pkg::FU_ALU, 12, 1, 1'b1, 2, 1'b1);
        queue_dispatch(1, rs_packet_pkg::FU_ALU, 13, 1, 1'b1, 2, 1'b1);
        run_cycle();
        run_cycle();
        assert (alu_valid == 2'b11) else value_error("alu valid vector", 3, int'(alu_valid));
        finish_test();

        start_test("capacity");
        for (int i = 0; i < 4; i++) begin
            queue_dispatch(0, rs_packet_pkg::FU_ALU, i, 20, 1'b0, 50, 1'b1);
            queue_dispatch(1, rs_packet_pkg::FU_MEM, i, 21, 1'b0, 50, 1'b1);
            run_cycle();
        end
        run_cycle();
        assert (open_entries == '0)
            else value_error("open_entries when full", 0, int'(open_entries));
        queue_broadcast(0, 20);
        repeat (4) run_cycle();
        assert (int'(open_entries) == DW)
            else value_error("open_entries after release", DW, int'(open_entries));
        drain();
        finish_test();

        start_test("random mix");
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            n = rand_bits(2);
            if (n > rs_config_pkg::RS_DEPTH - wait_set.num()) begin
                n = rs_config_pkg::RS_DEPTH - wait_set.num();
            end
            if (n > DW) n = DW;
            for (int lane = 0; lane < n; lane++) begin
                queue_dispatch(lane, rs_packet_pkg::fu_class_t'(rand_bits(2) % 3), rand_bits(6),
                               rand_bits(4), lfsr_bit(), rand_bits(4), lfsr_bit());
            end
            for (int lane = 0; lane < rs_config_pkg::CDB_WIDTH; lane++) begin
                if (lfsr_bit()) queue_broadcast(lane, rand_bits(4));
            end
            for (int u = 0; u < rs_config_pkg::NUM_ALU; u++) begin
                alu_busy_next[u] = (rand_bits(2) == 0);
            end
            mult_busy_next[0] = (rand_bits(2) == 0);
            mem_busy_next[0] = (rand_bits(2) == 0);
            run_cycle();
        end
        drain();
        finish_test();

        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== rs_top.f ====
+incdir+bench
logic/rs_config_pkg.sv
logic/rs_packet_pkg.sv
logic/psel_gen.sv
logic/rs_issue_select.sv
logic/rs_entry_array.sv
logic/rs_top.sv
bench/rs_tb.sv

// ==== Bender.yml ====
package:
  name: rs_top

sources:
  - files:
      - logic/rs_config_pkg.sv
      - logic/rs_packet_pkg.sv
      - logic/psel_gen.sv
      - logic/rs_issue_select.sv
      - logic/rs_entry_array.sv
      - logic/rs_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/rs_tb.sv
